// File: logic/decodeDefs_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// Instruction word width
`define DECODE_XLEN 32

// Field widths inside the instruction word
`define DECODE_OPCODE_W 7
`define DECODE_FUNCT3_W 3
`define DECODE_FUNCT7_W 7

`endif

// File: logic/decodePkg.sv
`include "decodeDefs_defs.svh"

package decodePkg;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [`DECODE_OPCODE_W-1:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opOpImm  = 7'b0010011,
        opOp     = 7'b0110011
    } opcodeE;

    // Class code handed from main decoder to ALU decoder
    typedef enum logic [3:0] {
        clsLui    = 4'd0,
        clsAuipc  = 4'd1,
        clsJal    = 4'd2,
        clsJalr   = 4'd3,
        clsBranch = 4'd4,
        clsLoad   = 4'd5,
        clsStore  = 4'd6,
        clsOpImm  = 4'd7,
        clsOp     = 4'd8
    } aluClassE;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluLt   = 4'd2,  // Signed
        aluGe   = 4'd3,  // Signed
        aluLtu  = 4'd4,
        aluGeu  = 4'd5,
        aluXor  = 4'd6,
        aluAnd  = 4'd7,
        aluOr   = 4'd8,
        aluSll  = 4'd9,
        aluSrl  = 4'd10,
        aluSra  = 4'd11,
        aluEq   = 4'd12,
        aluNe   = 4'd13
    } aluCtrlE;

    // Extension on write-back, size on store
    typedef enum logic [2:0] {
        sizeUByte = 3'b000,
        sizeSByte = 3'b001,
        sizeUHalf = 3'b010,
        sizeSHalf = 3'b011,
        sizeWord  = 3'b100
    } accessSizeE;

    // First ALU operand
    typedef enum logic [1:0] {
        src1Pc   = 2'b00,
        src1Zero = 2'b01,
        src1Rs1  = 2'b10
    } pcSrcE;

    // Second ALU operand
    typedef enum logic [2:0] {
        src2Rs2   = 3'b000,
        src2ImmUJ = 3'b001,
        src2ImmS  = 3'b010,
        src2ImmJr = 3'b011,
        src2ImmI  = 3'b100
    } op2SrcE;

endpackage

// File: logic/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;

    decodePkg::aluClassE aluClass;
    decodePkg::pcSrcE    aluSrc1;
    decodePkg::op2SrcE   aluSrc2;
    logic                memWrite;
    logic                memRead;
    logic                memToReg;
    logic                regWrite;
    logic                returnAddrToReg;  // Write PC+4 to rd
    logic                branch;
    logic                jump;
    logic                indirectJump;

    modport src (
        output aluClass, aluSrc1, aluSrc2, memWrite, memRead, memToReg,
        regWrite, returnAddrToReg, branch, jump, indirectJump
    );

    modport dst (
        input aluClass, aluSrc1, aluSrc2, memWrite, memRead, memToReg,
        regWrite, returnAddrToReg, branch, jump, indirectJump
    );

endinterface

// File: logic/mainDecoder.sv
`timescale 1ns/1ps
`include "decodeDefs_defs.svh"

module mainDecoder (
    input  logic [`DECODE_OPCODE_W-1:0] opcode,
    ctrlIf.src                          ctrl
);

    always_comb begin
        // Unknown opcode leaves everything inactive
        ctrl.aluClass        = decodePkg::clsLui;
        ctrl.aluSrc1         = decodePkg::src1Pc;
        ctrl.aluSrc2         = decodePkg::src2Rs2;
        ctrl.memWrite        = 1'b0;
        ctrl.memRead         = 1'b0;
        ctrl.memToReg        = 1'b0;
        ctrl.regWrite        = 1'b0;
        ctrl.returnAddrToReg = 1'b0;
        ctrl.branch          = 1'b0;
        ctrl.jump            = 1'b0;
        ctrl.indirectJump    = 1'b0;

        case (opcode)
            decodePkg::opLui: begin
                ctrl.aluClass = decodePkg::clsLui;
                ctrl.aluSrc1  = decodePkg::src1Zero;  // 0 + imm
                ctrl.aluSrc2  = decodePkg::src2ImmUJ;
                ctrl.regWrite = 1'b1;
            end
            decodePkg::opAuipc: begin
                ctrl.aluClass = decodePkg::clsAuipc;
                ctrl.aluSrc1  = decodePkg::src1Pc;
                ctrl.aluSrc2  = decodePkg::src2ImmUJ;
                ctrl.regWrite = 1'b1;
            end
            decodePkg::opJal: begin
                ctrl.aluClass        = decodePkg::clsJal;
                ctrl.aluSrc1         = decodePkg::src1Pc;  // Target is PC + offset
                ctrl.aluSrc2         = decodePkg::src2ImmUJ;
                ctrl.regWrite        = 1'b1;
                ctrl.returnAddrToReg = 1'b1;
                ctrl.jump            = 1'b1;
            end
            decodePkg::opJalr: begin
                ctrl.aluClass        = decodePkg::clsJalr;
                ctrl.aluSrc1         = decodePkg::src1Rs1;
                ctrl.aluSrc2         = decodePkg::src2ImmJr;
                ctrl.regWrite        = 1'b1;
                ctrl.returnAddrToReg = 1'b1;
                ctrl.jump            = 1'b1;
                ctrl.indirectJump    = 1'b1;
            end
            decodePkg::opBranch: begin
                ctrl.aluClass = decodePkg::clsBranch;
                ctrl.aluSrc1  = decodePkg::src1Rs1;  // Compare rs1 against rs2
                ctrl.aluSrc2  = decodePkg::src2Rs2;
                ctrl.branch   = 1'b1;
            end
            decodePkg::opLoad: begin
                ctrl.aluClass = decodePkg::clsLoad;
                ctrl.aluSrc1  = decodePkg::src1Rs1;
                ctrl.aluSrc2  = decodePkg::src2ImmI;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            decodePkg::opStore: begin
                ctrl.aluClass = decodePkg::clsStore;
                ctrl.aluSrc1  = decodePkg::src1Rs1;
                ctrl.aluSrc2  = decodePkg::src2ImmS;
                ctrl.memWrite = 1'b1;
            end
            decodePkg::opOpImm: begin
                ctrl.aluClass = decodePkg::clsOpImm;
                ctrl.aluSrc1  = decodePkg::src1Rs1;
                ctrl.aluSrc2  = decodePkg::src2ImmI;  // Shamt swap done downstream
                ctrl.regWrite = 1'b1;
            end
            decodePkg::opOp: begin
                ctrl.aluClass = decodePkg::clsOp;
                ctrl.aluSrc1  = decodePkg::src1Rs1;
                ctrl.aluSrc2  = decodePkg::src2Rs2;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: logic/aluDecoder.sv
`timescale 1ns/1ps
`include "decodeDefs_defs.svh"

module aluDecoder (
    ctrlIf.dst                          ctrl,
    input  logic [`DECODE_FUNCT3_W-1:0] funct3,
    input  logic [`DECODE_FUNCT7_W-1:0] funct7,
    output decodePkg::aluCtrlE          aluCtrl,
    output decodePkg::accessSizeE       regWriteSize,
    output decodePkg::accessSizeE       memWriteSize,
    output logic                        shamtOverImm
);

    logic funct7Legal;  // Only bit 5 may be set
    logic funct7Alt;    // SUB / SRA / SRAI variant

    assign funct7Legal = ({funct7[6], funct7[4:0]} == 6'd0);
    assign funct7Alt   = funct7[5];

    always_comb begin
        aluCtrl      = decodePkg::aluAdd;  // Address and upper-imm classes add
        regWriteSize = decodePkg::sizeWord;
        memWriteSize = decodePkg::sizeWord;
        shamtOverImm = 1'b0;

        case (ctrl.aluClass)
            decodePkg::clsBranch: begin
                case (funct3)
                    3'b000: aluCtrl = decodePkg::aluEq;   // BEQ
                    3'b001: aluCtrl = decodePkg::aluNe;   // BNE
                    3'b100: aluCtrl = decodePkg::aluLt;   // BLT
                    3'b101: aluCtrl = decodePkg::aluGe;   // BGE
                    3'b110: aluCtrl = decodePkg::aluLtu;  // BLTU
                    3'b111: aluCtrl = decodePkg::aluGeu;  // BGEU
                    default: ;
                endcase
            end
            decodePkg::clsLoad: begin
                case (funct3)
                    3'b000: regWriteSize = decodePkg::sizeSByte;  // LB
                    3'b001: regWriteSize = decodePkg::sizeSHalf;  // LH
                    3'b010: regWriteSize = decodePkg::sizeWord;   // LW
                    3'b100: regWriteSize = decodePkg::sizeUByte;  // LBU
                    3'b101: regWriteSize = decodePkg::sizeUHalf;  // LHU
                    default: ;
                endcase
            end
            decodePkg::clsStore: begin
                case (funct3)
                    3'b000: memWriteSize = decodePkg::sizeUByte;  // SB
                    3'b001: memWriteSize = decodePkg::sizeUHalf;  // SH
                    3'b010: memWriteSize = decodePkg::sizeWord;   // SW
                    default: ;
                endcase
            end
            decodePkg::clsOpImm: begin
                case (funct3)
                    3'b000: aluCtrl = decodePkg::aluAdd;  // ADDI
                    3'b010: aluCtrl = decodePkg::aluLt;   // SLTI
                    3'b011: aluCtrl = decodePkg::aluLtu;  // SLTIU
                    3'b100: aluCtrl = decodePkg::aluXor;
                    3'b110: aluCtrl = decodePkg::aluOr;
                    3'b111: aluCtrl = decodePkg::aluAnd;
                    3'b001: begin
                        aluCtrl      = decodePkg::aluSll;
                        shamtOverImm = 1'b1;
                    end
                    3'b101: begin
                        // Other funct7 patterns are not shifts
                        if (funct7Legal) begin
                            aluCtrl      = funct7Alt ? decodePkg::aluSra : decodePkg::aluSrl;
                            shamtOverImm = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            decodePkg::clsOp: begin
                case (funct3)
                    3'b000: begin
                        if (funct7Legal && funct7Alt) begin
                            aluCtrl = decodePkg::aluSub;
                        end
                    end
                    3'b001: aluCtrl = decodePkg::aluSll;  // Amount from rs2[4:0]
                    3'b010: aluCtrl = decodePkg::aluLt;
                    3'b011: aluCtrl = decodePkg::aluLtu;
                    3'b100: aluCtrl = decodePkg::aluXor;
                    3'b101: begin
                        if (funct7Legal) begin
                            aluCtrl = funct7Alt ? decodePkg::aluSra : decodePkg::aluSrl;
                        end
                    end
                    3'b110: aluCtrl = decodePkg::aluOr;
                    3'b111: aluCtrl = decodePkg::aluAnd;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: logic/decodeReg.sv
`timescale 1ns/1ps

module decodeReg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instrValid,
    ctrlIf.dst                    ctrl,
    input  decodePkg::aluCtrlE    decAluCtrl,
    input  decodePkg::accessSizeE decRegWriteSize,
    input  decodePkg::accessSizeE decMemWriteSize,
    input  logic                  decShamtOverImm,
    output logic                  ctrlValid,
    output decodePkg::aluCtrlE    aluCtrl,
    output decodePkg::pcSrcE      aluSrc1,
    output decodePkg::op2SrcE     aluSrc2,
    output logic                  memWrite,
    output logic                  memRead,
    output logic                  memToReg,
    output logic                  regWrite,
    output logic                  returnAddrToReg,
    output logic                  branch,
    output logic                  jump,
    output logic                  indirectJump,
    output decodePkg::accessSizeE regWriteSize,
    output decodePkg::accessSizeE memWriteSize,
    output logic                  shamtOverImm
);

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlValid <= 1'b0;
        end else begin
            ctrlValid <= instrValid;
        end

        // A bubble loads zeros so idle cycles look like reset
        if (rst || !instrValid) begin
            aluCtrl         <= decodePkg::aluAdd;
            aluSrc1         <= decodePkg::src1Pc;
            aluSrc2         <= decodePkg::src2Rs2;
            memWrite        <= 1'b0;
            memRead         <= 1'b0;
            memToReg        <= 1'b0;
            regWrite        <= 1'b0;
            returnAddrToReg <= 1'b0;
            branch          <= 1'b0;
            jump            <= 1'b0;
            indirectJump    <= 1'b0;
            regWriteSize    <= decodePkg::sizeUByte;
            memWriteSize    <= decodePkg::sizeUByte;
            shamtOverImm    <= 1'b0;
        end else begin
            aluCtrl         <= decAluCtrl;
            aluSrc1         <= ctrl.aluSrc1;
            aluSrc2         <= ctrl.aluSrc2;
            memWrite        <= ctrl.memWrite;
            memRead         <= ctrl.memRead;
            memToReg        <= ctrl.memToReg;
            regWrite        <= ctrl.regWrite;
            returnAddrToReg <= ctrl.returnAddrToReg;
            branch          <= ctrl.branch;
            jump            <= ctrl.jump;
            indirectJump    <= ctrl.indirectJump;
            regWriteSize    <= decRegWriteSize;
            memWriteSize    <= decMemWriteSize;
            shamtOverImm    <= decShamtOverImm;
        end
    end

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/1ps
`include "decodeDefs_defs.svh"

module decodeStage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`DECODE_XLEN-1:0]  instr,
    input  logic                     instrValid,
    output logic                     ctrlValid,
    output decodePkg::aluCtrlE       aluCtrl,
    output decodePkg::pcSrcE         aluSrc1,
    output decodePkg::op2SrcE        aluSrc2,
    output logic                     memWrite,
    output logic                     memRead,
    output logic                     memToReg,
    output logic                     regWrite,
    output logic                     returnAddrToReg,
    output logic                     branch,
    output logic                     jump,
    output logic                     indirectJump,
    output decodePkg::accessSizeE    regWriteSize,
    output decodePkg::accessSizeE    memWriteSize,
    output logic                     shamtOverImm
);

    decodePkg::aluCtrlE    decAluCtrl;
    decodePkg::accessSizeE decRegWriteSize;
    decodePkg::accessSizeE decMemWriteSize;
    logic                  decShamtOverImm;

    ctrlIf ctrlBus ();  // Main decoder levels plus class code

    mainDecoder uMainDecoder (
        .opcode (instr[`DECODE_OPCODE_W-1:0]),
        .ctrl   (ctrlBus.src)
    );

    aluDecoder uAluDecoder (
        .ctrl         (ctrlBus.dst),
        .funct3       (instr[12 +: `DECODE_FUNCT3_W]),  // instr[14:12]
        .funct7       (instr[25 +: `DECODE_FUNCT7_W]),  // instr[31:25]
        .aluCtrl      (decAluCtrl),
        .regWriteSize (decRegWriteSize),
        .memWriteSize (decMemWriteSize),
        .shamtOverImm (decShamtOverImm)
    );

    decodeReg uDecodeReg (
        .clk             (clk),
        .rst             (rst),
        .instrValid      (instrValid),
        .ctrl            (ctrlBus.dst),
        .decAluCtrl      (decAluCtrl),
        .decRegWriteSize (decRegWriteSize),
        .decMemWriteSize (decMemWriteSize),
        .decShamtOverImm (decShamtOverImm),
        .ctrlValid       (ctrlValid),
        .aluCtrl         (aluCtrl),
        .aluSrc1         (aluSrc1),
        .aluSrc2         (aluSrc2),
        .memWrite        (memWrite),
        .memRead         (memRead),
        .memToReg        (memToReg),
        .regWrite        (regWrite),
        .returnAddrToReg (returnAddrToReg),
        .branch          (branch),
        .jump            (jump),
        .indirectJump    (indirectJump),
        .regWriteSize    (regWriteSize),
        .memWriteSize    (memWriteSize),
        .shamtOverImm    (shamtOverImm)
    );

endmodule

// File: verif/decodeChecker.sv
`timescale 1ns/1ps
`include "decodeDefs_defs.svh"

module decodeChecker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`DECODE_XLEN-1:0] instr,
    input  logic                    instrValid,
    input  logic                    ctrlValid,
    input  decodePkg::aluCtrlE      aluCtrl,
    input  decodePkg::pcSrcE        aluSrc1,
    input  decodePkg::op2SrcE       aluSrc2,
    input  logic                    memWrite,
    input  logic                    memRead,
    input  logic                    memToReg,
    input  logic                    regWrite,
    input  logic                    returnAddrToReg,
    input  logic                    branch,
    input  logic                    jump,
    input  logic                    indirectJump,
    input  decodePkg::accessSizeE   regWriteSize,
    input  decodePkg::accessSizeE   memWriteSize,
    input  logic                    shamtOverImm,
    output int                      checkCount,
    output int                      errorCount
);

    typedef struct packed {
        logic                  valid;
        decodePkg::aluCtrlE    aluCtrl;
        decodePkg::pcSrcE      aluSrc1;
        decodePkg::op2SrcE     aluSrc2;
        logic                  memWrite;
        logic                  memRead;
        logic                  memToReg;
        logic                  regWrite;
        logic                  returnAddrToReg;
        logic                  branch;
        logic                  jump;
        logic                  indirectJump;
        decodePkg::accessSizeE regWriteSize;
        decodePkg::accessSizeE memWriteSize;
        logic                  shamtOverImm;
    } expectT;

    expectT                  expected;       // Due on the outputs after the next edge
    logic [`DECODE_XLEN-1:0] expectedInstr;
    logic                    havePending = 1'b0;
    int                      nChecks = 0;
    int                      nErrors = 0;

    assign checkCount = nChecks;
    assign errorCount = nErrors;

    function automatic decodePkg::aluCtrlE arithOp(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return decodePkg::aluAdd;
            3'b001:  return decodePkg::aluSll;
            3'b010:  return decodePkg::aluLt;
            3'b011:  return decodePkg::aluLtu;
            3'b100:  return decodePkg::aluXor;
            3'b101:  return alt ? decodePkg::aluSra : decodePkg::aluSrl;
            3'b110:  return decodePkg::aluOr;
            default: return decodePkg::aluAnd;
        endcase
    endfunction

    function automatic decodePkg::aluCtrlE branchCompare(input logic [2:0] f3);
        case (f3)
            3'b000:  return decodePkg::aluEq;
            3'b001:  return decodePkg::aluNe;
            3'b100:  return decodePkg::aluLt;
            3'b101:  return decodePkg::aluGe;
            3'b110:  return decodePkg::aluLtu;
            3'b111:  return decodePkg::aluGeu;
            default: return decodePkg::aluAdd;  // 010 and 011 are not branches
        endcase
    endfunction

    function automatic decodePkg::accessSizeE loadExtend(input logic [2:0] f3);
        case (f3)
            3'b000:  return decodePkg::sizeSByte;
            3'b001:  return decodePkg::sizeSHalf;
            3'b100:  return decodePkg::sizeUByte;
            3'b101:  return decodePkg::sizeUHalf;
            default: return decodePkg::sizeWord;
        endcase
    endfunction

    function automatic decodePkg::accessSizeE storeSize(input logic [2:0] f3);
        case (f3)
            3'b000:  return decodePkg::sizeUByte;
            3'b001:  return decodePkg::sizeUHalf;
            default: return decodePkg::sizeWord;
        endcase
    endfunction

    // Expected registered fields for one valid instruction word
    function automatic expectT refModel(input logic [`DECODE_XLEN-1:0] word);
        expectT     e;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       stdF7;
        logic       altF7;
        f3             = word[14:12];
        f7             = word[31:25];
        stdF7          = (f7 == 7'b0000000) || (f7 == 7'b0100000);
        altF7          = (f7 == 7'b0100000);
        e              = '0;
        e.valid        = 1'b1;
        e.regWriteSize = decodePkg::sizeWord;
        e.memWriteSize = decodePkg::sizeWord;
        case (word[6:0])
            7'b0110111: begin  // LUI
                e.aluSrc1  = decodePkg::src1Zero;
                e.aluSrc2  = decodePkg::src2ImmUJ;
                e.regWrite = 1'b1;
            end
            7'b0010111: begin  // AUIPC
                e.aluSrc2  = decodePkg::src2ImmUJ;
                e.regWrite = 1'b1;
            end
            7'b1101111: begin  // JAL
                e.aluSrc2         = decodePkg::src2ImmUJ;
                e.regWrite        = 1'b1;
                e.returnAddrToReg = 1'b1;
                e.jump            = 1'b1;
            end
            7'b1100111: begin  // JALR
                e.aluSrc1         = decodePkg::src1Rs1;
                e.aluSrc2         = decodePkg::src2ImmJr;
                e.regWrite        = 1'b1;
                e.returnAddrToReg = 1'b1;
                e.jump            = 1'b1;
                e.indirectJump    = 1'b1;
            end
            7'b1100011: begin
                e.aluSrc1 = decodePkg::src1Rs1;
                e.branch  = 1'b1;
                e.aluCtrl = branchCompare(f3);
            end
            7'b0000011: begin
                e.aluSrc1      = decodePkg::src1Rs1;
                e.aluSrc2      = decodePkg::src2ImmI;
                e.memRead      = 1'b1;
                e.memToReg     = 1'b1;
                e.regWrite     = 1'b1;
                e.regWriteSize = loadExtend(f3);
            end
            7'b0100011: begin
                e.aluSrc1      = decodePkg::src1Rs1;
                e.aluSrc2      = decodePkg::src2ImmS;
                e.memWrite     = 1'b1;
                e.memWriteSize = storeSize(f3);
            end
            7'b0010011: begin
                e.aluSrc1  = decodePkg::src1Rs1;
                e.aluSrc2  = decodePkg::src2ImmI;
                e.regWrite = 1'b1;
                // A right shift with a bad funct7 stays ADD
                if (!(f3 == 3'b101 && !stdF7)) begin
                    e.aluCtrl      = arithOp(f3, altF7);
                    e.shamtOverImm = (f3 == 3'b001) || (f3 == 3'b101);
                end
            end
            7'b0110011: begin
                e.aluSrc1  = decodePkg::src1Rs1;
                e.regWrite = 1'b1;
                if (f3 == 3'b000 && altF7) begin
                    e.aluCtrl = decodePkg::aluSub;
                end else if (!(f3 == 3'b101 && !stdF7)) begin
                    e.aluCtrl = arithOp(f3, altF7);
                end
            end
            default: ;  // Levels off, sizes word
        endcase
        return e;
    endfunction

    task automatic compareField(input string name, input logic [3:0] got,
                                input logic [3:0] want);
        if (got !== want) begin
            nErrors = nErrors + 1;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h (instr %08h)",
                     $time, name, got, want, expectedInstr);
        end
    endtask

    always @(posedge clk) begin
        if (rst || !instrValid) begin
            expected <= '0;  // Bubble or reset clears everything
        end else begin
            expected <= refModel(instr);
        end
        expectedInstr <= instr;
        havePending   <= 1'b1;
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (havePending) begin
            nChecks = nChecks + 1;
            compareField("ctrlValid", 4'(ctrlValid), 4'(expected.valid));
            compareField("aluCtrl", 4'(aluCtrl), 4'(expected.aluCtrl));
            compareField("aluSrc1", 4'(aluSrc1), 4'(expected.aluSrc1));
            compareField("aluSrc2", 4'(aluSrc2), 4'(expected.aluSrc2));
            compareField("memWrite", 4'(memWrite), 4'(expected.memWrite));
            compareField("memRead", 4'(memRead), 4'(expected.memRead));
            compareField("memToReg", 4'(memToReg), 4'(expected.memToReg));
            compareField("regWrite", 4'(regWrite), 4'(expected.regWrite));
            compareField("returnAddrToReg", 4'(returnAddrToReg), 4'(expected.returnAddrToReg));
            compareField("branch", 4'(branch), 4'(expected.branch));
            compareField("jump", 4'(jump), 4'(expected.jump));
            compareField("indirectJump", 4'(indirectJump), 4'(expected.indirectJump));
            compareField("regWriteSize", 4'(regWriteSize), 4'(expected.regWriteSize));
            compareField("memWriteSize", 4'(memWriteSize), 4'(expected.memWriteSize));
            compareField("shamtOverImm", 4'(shamtOverImm), 4'(expected.shamtOverImm));
        end
    end

endmodule

// File: verif/decodeTb.sv
`timescale 1ns/1ps
`include "decodeDefs_defs.svh"

module decodeTb;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 8;
    localparam int IdleCycles  = 10;
    localparam int OpcodeCount = 11;
    localparam int MemBrCount  = 24;
    localparam int ArithCount  = 21;
    localparam int RandomCount = 300;
    localparam int TestCount   = 5;  // Each test ends with one drain cycle
    localparam int StimCycles  = IdleCycles + OpcodeCount + MemBrCount + ArithCount
                                 + RandomCount + TestCount;
    localparam int TimeoutNs   = 2 * (StimCycles + ResetCycles) * ClkPeriod;

    logic                    clk;
    logic                    rst;
    logic [`DECODE_XLEN-1:0] instr;
    logic                    instrValid;
    logic                    ctrlValid;
    decodePkg::aluCtrlE      aluCtrl;
    decodePkg::pcSrcE        aluSrc1;
    decodePkg::op2SrcE       aluSrc2;
    logic                    memWrite;
    logic                    memRead;
    logic                    memToReg;
    logic                    regWrite;
    logic                    returnAddrToReg;
    logic                    branch;
    logic                    jump;
    logic                    indirectJump;
    decodePkg::accessSizeE   regWriteSize;
    decodePkg::accessSizeE   memWriteSize;
    logic                    shamtOverImm;
    int                      checkCount;
    int                      errorCount;
    int                      errorsBefore;  // Error count when the current test began

    decodeStage dut (
        .clk (clk), .rst (rst), .instr (instr), .instrValid (instrValid),
        .ctrlValid (ctrlValid), .aluCtrl (aluCtrl), .aluSrc1 (aluSrc1), .aluSrc2 (aluSrc2),
        .memWrite (memWrite), .memRead (memRead), .memToReg (memToReg),
        .regWrite (regWrite), .returnAddrToReg (returnAddrToReg), .branch (branch),
        .jump (jump), .indirectJump (indirectJump), .regWriteSize (regWriteSize),
        .memWriteSize (memWriteSize), .shamtOverImm (shamtOverImm)
    );

    decodeChecker chk (
        .clk (clk), .rst (rst), .instr (instr), .instrValid (instrValid),
        .ctrlValid (ctrlValid), .aluCtrl (aluCtrl), .aluSrc1 (aluSrc1), .aluSrc2 (aluSrc2),
        .memWrite (memWrite), .memRead (memRead), .memToReg (memToReg),
        .regWrite (regWrite), .returnAddrToReg (returnAddrToReg), .branch (branch),
        .jump (jump), .indirectJump (indirectJump), .regWriteSize (regWriteSize),
        .memWriteSize (memWriteSize), .shamtOverImm (shamtOverImm),
        .checkCount (checkCount), .errorCount (errorCount)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    task automatic applyWord(input logic [`DECODE_XLEN-1:0] word, input logic valid);
        @(posedge clk);
        #1;
        instr      = word;
        instrValid = valid;
    endtask

    function automatic logic [`DECODE_XLEN-1:0] makeInstr(input logic [6:0] f7,
                                                          input logic [2:0] f3,
                                                          input logic [6:0] opc);
        return {f7, 5'd2, 5'd1, f3, 5'd3, opc};  // rs2=2, rs1=1, rd=3
    endfunction

    function automatic logic [6:0] pickOpcode(input int idx);
        case (idx)
            0:       return decodePkg::opLui;
            1:       return decodePkg::opAuipc;
            2:       return decodePkg::opJal;
            3:       return decodePkg::opJalr;
            4:       return decodePkg::opBranch;
            5:       return decodePkg::opLoad;
            6:       return decodePkg::opStore;
            7:       return decodePkg::opOpImm;
            default: return decodePkg::opOp;
        endcase
    endfunction

    // Drain the last instruction, then report the test
    task automatic finishTest(input string name);
        int failed;
        applyWord('0, 1'b0);
        @(negedge clk);
        #1;
        failed       = errorCount - errorsBefore;
        errorsBefore = errorCount;
        $display("Test %s: %s (%0d mismatches)", name, failed == 0 ? "ok" : "failed", failed);
    endtask

    task automatic resetIdleTest();
        repeat (IdleCycles) applyWord(makeInstr(7'h20, 3'd0, decodePkg::opOp), 1'b0);
        finishTest("idle after reset");
    endtask

    task automatic opcodeTest();
        for (int i = 0; i < 9; i++) begin
            applyWord(makeInstr(7'd0, 3'd0, pickOpcode(i)), 1'b1);
        end
        applyWord(makeInstr(7'h7f, 3'd7, 7'b1111111), 1'b1);
        applyWord(makeInstr(7'd0, 3'd0, 7'b0001011), 1'b1);  // custom-0 space
        finishTest("opcodes");
    endtask

    task automatic memBranchTest();
        for (int f = 0; f < 8; f++) begin
            applyWord(makeInstr(7'd0, 3'(f), decodePkg::opBranch), 1'b1);
            applyWord(makeInstr(7'd0, 3'(f), decodePkg::opLoad), 1'b1);
            applyWord(makeInstr(7'd0, 3'(f), decodePkg::opStore), 1'b1);
        end
        finishTest("branch, load and store funct3");
    endtask

    task automatic arithTest();
        for (int f = 0; f < 8; f++) begin
            applyWord(makeInstr(7'd0, 3'(f), decodePkg::opOpImm), 1'b1);
            applyWord(makeInstr(7'd0, 3'(f), decodePkg::opOp), 1'b1);
        end
        applyWord(makeInstr(7'h20, 3'd5, decodePkg::opOpImm), 1'b1);  // SRAI
        applyWord(makeInstr(7'h01, 3'd5, decodePkg::opOpImm), 1'b1);
        applyWord(makeInstr(7'h20, 3'd0, decodePkg::opOp), 1'b1);     // SUB
        applyWord(makeInstr(7'h20, 3'd5, decodePkg::opOp), 1'b1);     // SRA
        applyWord(makeInstr(7'h01, 3'd0, decodePkg::opOp), 1'b1);
        finishTest("arithmetic and shifts");
    endtask

    task automatic randomTest();
        logic [`DECODE_XLEN-1:0] word;
        int                      sel;
        logic                    valid;
        repeat (RandomCount) begin
            word = $urandom;
            sel  = $urandom % 10;
            if (sel < 9) begin
                word[6:0] = pickOpcode(sel);  // Mostly real opcodes
            end
            sel = $urandom % 4;
            if (sel == 0) begin
                word[31:25] = 7'h00;
            end else if (sel == 1) begin
                word[31:25] = 7'h20;
            end
            valid = ($urandom % 4) != 0;
            applyWord(word, valid);
        end
        finishTest("random stream");
    endtask

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired after %0d ns before the tests finished", TimeoutNs);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        instr        = makeInstr(7'd0, 3'd0, decodePkg::opJalr);  // Reset must win over it
        instrValid   = 1'b1;
        errorsBefore = 0;
        void'($urandom(32'h506f));
        repeat (ResetCycles) @(posedge clk);
        #1;
        rst        = 1'b0;
        instrValid = 1'b0;
        resetIdleTest();
        opcodeTest();
        memBranchTest();
        arithTest();
        randomTest();
        $display("Summary: %0d cycles checked, %0d mismatches", checkCount, errorCount);
        if (errorCount == 0 && checkCount > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+logic
logic/decodePkg.sv
logic/ctrlIf.sv
logic/mainDecoder.sv
logic/aluDecoder.sv
logic/decodeReg.sv
logic/decodeStage.sv
verif/decodeChecker.sv
verif/decodeTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module decodeTb \
    -Mdir obj_dir -o decodeSim -f build.f \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/decodeSim > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
